/* long_divider.sv */
/*
 * Restoring long divider, one quotient bit per cycle. req_i must stay
 * stable from start until done. A zero divisor skips straight to finish.
 */
`timescale 1ns/1ps
`default_nettype none

module long_divider (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  muldiv_pkg::md_req_t req_i,
  output logic                done_o,
  output muldiv_pkg::word_t   result_o
);

  import muldiv_pkg::*;

  typedef enum logic [2:0] {
    DV_IDLE,
    DV_ABS_A,
    DV_ABS_B,
    DV_COMP,
    DV_LAST,
    DV_SIGN,
    DV_FINISH
  } div_state_e;

  div_state_e        state_q, state_d;
  logic [cnt_w-1:0]  cnt_q, cnt_d;
  logic              done_q;
  word_t             numer_q, numer_d;
  word_t             denom_q, denom_d;
  word_t             quot_q, quot_d;
  acc_t              rem_q, rem_d;
  logic [word_w:0]   sub_a;
  logic [word_w:0]   sub_b;
  logic [word_w+1:0] diff;
  logic              ge;
  word_t             next_rem;
  word_t             next_quot;
  word_t             one_shift;
  logic              sign_a;
  logic              sign_b;
  logic              is_div;
  logic              quot_neg;

  assign sign_a   = req_i.signed_mode[0] & req_i.op_a[word_w-1];
  assign sign_b   = req_i.signed_mode[1] & req_i.op_b[word_w-1];
  assign is_div   = (req_i.op == MD_OP_DIV);
  // divide by zero never reaches the sign step, so no exception is needed
  assign quot_neg = sign_a ^ sign_b;

  ////////////////////
  // subtractor
  ////////////////////

  // shared by abs, compare and final negation; top bit is the borrow
  assign diff = {1'b0, sub_a} - {1'b0, sub_b};
  assign ge   = ~diff[word_w+1];

  assign next_rem  = ge ? diff[word_w-1:0] : rem_q[word_w-1:0];
  assign one_shift = {{(word_w-1){1'b0}}, 1'b1} << cnt_q;
  assign next_quot = ge ? (quot_q | one_shift) : quot_q;

  ////////////////////
  // state machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    numer_d = numer_q;
    denom_d = denom_q;
    quot_d  = quot_q;
    rem_d   = rem_q;
    sub_a   = '0;
    sub_b   = {1'b0, denom_q};
    case (state_q)
      DV_IDLE: begin
        if (start_i) begin
          if (req_i.op_b == '0) begin
            // quotient all ones, remainder is the dividend
            rem_d   = is_div ? {2'b00, {word_w{1'b1}}} : {2'b00, req_i.op_a};
            state_d = DV_FINISH;
          end else begin
            state_d = DV_ABS_A;
          end
        end
      end
      DV_ABS_A: begin
        sub_b   = {1'b0, req_i.op_a};
        numer_d = sign_a ? diff[word_w-1:0] : req_i.op_a;
        quot_d  = '0;
        state_d = DV_ABS_B;
      end
      DV_ABS_B: begin
        sub_b   = {1'b0, req_i.op_b};
        denom_d = sign_b ? diff[word_w-1:0] : req_i.op_b;
        // first dividend bit already shifted in
        rem_d   = {{(acc_w-1){1'b0}}, numer_q[word_w-1]};
        cnt_d   = '1;
        state_d = DV_COMP;
      end
      DV_COMP: begin
        sub_a   = rem_q[word_w:0];
        quot_d  = next_quot;
        cnt_d   = cnt_q - 1'b1;
        rem_d   = {1'b0, next_rem, numer_q[cnt_d]};
        if (cnt_q == 1) begin
          state_d = DV_LAST;
        end
      end
      DV_LAST: begin
        // bit 0, then only the wanted word is kept
        sub_a   = rem_q[word_w:0];
        rem_d   = is_div ? {2'b00, next_quot} : {2'b00, next_rem};
        state_d = DV_SIGN;
      end
      DV_SIGN: begin
        sub_b = {1'b0, rem_q[word_w-1:0]};
        if (is_div ? quot_neg : sign_a) begin
          rem_d = {2'b00, diff[word_w-1:0]};
        end
        state_d = DV_FINISH;
      end
      DV_FINISH: begin
        state_d = DV_IDLE;
      end
      default: begin
        state_d = DV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DV_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_q  <= (state_q == DV_FINISH);
    end
  end

  always_ff @(posedge clk_i) begin
    numer_q <= numer_d;
    denom_q <= denom_d;
    quot_q  <= quot_d;
    rem_q   <= rem_d;
  end

  // rem_q holds the result from the last step until the next start
  assign result_o = rem_q[word_w-1:0];
  assign done_o   = done_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {DV_IDLE, DV_ABS_A, DV_ABS_B, DV_COMP, DV_LAST, DV_SIGN, DV_FINISH});

  // the top must not restart the divider while a division is running
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> state_q == DV_IDLE);

endmodule

`default_nettype wire

/* muldiv_pkg.sv */
/*
 * Types shared by the multiply/divide unit. Operands are 32 bits wide and
 * the vector element width only has an effect on MUL.
 */
`default_nettype none

package muldiv_pkg;

  ////////////////////
  // widths
  ////////////////////

  // operand and result width
  localparam int unsigned word_w = 32;
  // one half-operand, feeds a 17-bit multiplier with its sign bit
  localparam int unsigned half_w = 16;
  // partial product sum or shifted remainder
  localparam int unsigned acc_w  = 34;
  // divider bit counter, counts 31 down to 0
  localparam int unsigned cnt_w  = 5;

  typedef logic [word_w-1:0] word_t;
  typedef logic [acc_w-1:0]  acc_t;

  ////////////////////
  // encodings
  ////////////////////

  typedef enum logic [1:0] {
    MD_OP_MULL = 2'd0,
    MD_OP_MULH = 2'd1,
    MD_OP_DIV  = 2'd2,
    MD_OP_REM  = 2'd3
  } md_op_e;

  // 2'd3 is not a legal width and falls back to the 32-bit behaviour
  typedef enum logic [1:0] {
    VSEW_8  = 2'd0,
    VSEW_16 = 2'd1,
    VSEW_32 = 2'd2
  } vsew_e;

  ////////////////////
  // request
  ////////////////////

  // signed_mode bit 0 marks op_a signed, bit 1 marks op_b signed
  typedef struct packed {
    md_op_e     op;
    logic [1:0] signed_mode;
    logic       vec;
    vsew_e      vsew;
    word_t      op_a;
    word_t      op_b;
  } md_req_t;

endpackage

`default_nettype wire

/* muldiv_tests.txt */
# op signed_mode vec vsew op_a op_b expected, all hex
# op 0=MUL 1=MULH 2=DIV 3=REM, vsew 0=8 1=16 2=32
0 0 0 2 00000007 00000006 0000002A
0 3 0 2 FFFFFFFF FFFFFFFF 00000001
0 0 0 2 12345678 9ABCDEF0 242D2080
1 0 0 2 12345678 9ABCDEF0 0B00EA4E
1 3 0 2 12345678 9ABCDEF0 F8CC93D6
1 1 0 2 9ABCDEF0 12345678 F8CC93D6
1 3 0 2 FFFFFFFF FFFFFFFF 00000000
1 0 0 2 FFFFFFFF FFFFFFFF FFFFFFFE
1 1 0 2 FFFFFFFF FFFFFFFF FFFFFFFF
1 3 0 2 80000000 80000000 40000000
1 3 0 2 80000000 7FFFFFFF C0000000
1 2 0 2 00000002 FFFFFFFF FFFFFFFF
0 0 1 0 7F10FF03 020FFF05 FEF0010F
0 0 1 0 80808080 02030405 00800080
0 0 1 1 12345678 9ABCDEF0 A6302080
0 0 1 1 FFFF0003 FFFF0007 00010015
0 0 1 2 12345678 9ABCDEF0 242D2080
1 0 1 0 12345678 9ABCDEF0 0B00EA4E
2 3 0 2 00000014 00000006 00000003
3 3 0 2 00000014 00000006 00000002
2 3 0 2 FFFFFFEC 00000006 FFFFFFFD
3 3 0 2 FFFFFFEC 00000006 FFFFFFFE
3 3 0 2 00000014 FFFFFFFA 00000002
2 3 0 2 FFFFFFEC FFFFFFFA 00000003
3 3 0 2 FFFFFFEC FFFFFFFA FFFFFFFE
2 0 0 2 FFFFFFEC 00000006 2AAAAAA7
3 0 0 2 FFFFFFEC 00000006 00000002
2 0 0 2 9ABCDEF0 12345678 00000008
3 0 0 2 9ABCDEF0 12345678 091A2B30
2 3 0 2 80000000 FFFFFFFF 80000000
3 3 0 2 80000000 FFFFFFFF 00000000
2 3 0 2 12345678 00000000 FFFFFFFF
3 3 0 2 FFFFFFEC 00000000 FFFFFFEC
2 0 0 2 FFFFFFFF 00000001 FFFFFFFF

/* muldiv_unit.sv */
/*
 * Multiply/divide unit with a request/valid handshake and no result
 * back-pressure. result_o holds until the next valid_o pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  muldiv_pkg::md_req_t req_i,
  output logic                ready_o,
  output logic                valid_o,
  output muldiv_pkg::word_t   result_o
);

  import muldiv_pkg::*;

  md_req_t req_q;
  logic    accept;
  logic    busy_q;
  logic    start_q;
  logic    valid_q;
  word_t   result_q;
  logic    is_mul;
  logic    mul_start, div_start;
  logic    mul_done, div_done;
  word_t   mul_result, div_result;

  assign ready_o = ~busy_q;
  assign accept  = req_valid_i & ready_o;

  // steer the start pulse by operation class
  assign is_mul    = (req_q.op == MD_OP_MULL) || (req_q.op == MD_OP_MULH);
  assign mul_start = start_q & is_mul;
  assign div_start = start_q & ~is_mul;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      start_q  <= 1'b0;
      valid_q  <= 1'b0;
      result_q <= '0;
    end else begin
      start_q <= accept;
      valid_q <= mul_done | div_done;
      // ready returns the cycle after valid_o
      if (accept) begin
        busy_q <= 1'b1;
      end else if (valid_q) begin
        busy_q <= 1'b0;
      end
      if (mul_done) begin
        result_q <= mul_result;
      end else if (div_done) begin
        result_q <= div_result;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  mult_seq u_mult (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (mul_start),
    .req_i    (req_q),
    .done_o   (mul_done),
    .result_o (mul_result)
  );

  long_divider u_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (div_start),
    .req_i    (req_q),
    .done_o   (div_done),
    .result_o (div_result)
  );

  assign valid_o  = valid_q;
  assign result_o = result_q;

  // only one engine runs per request
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(mul_done && div_done));

endmodule

`default_nettype wire

/* mult_seq.sv */
/*
 * Multiply sequencer. MUL finishes one cycle after start, MULH two.
 * req_i must stay stable from start until done.
 */
`timescale 1ns/1ps
`default_nettype none

module mult_seq (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  muldiv_pkg::md_req_t req_i,
  output logic                done_o,
  output muldiv_pkg::word_t   result_o
);

  import muldiv_pkg::*;

  typedef enum logic {
    PH_LOW,
    PH_HIGH
  } mul_phase_e;

  mul_phase_e phase_q, phase_d;
  logic       done_q, done_d;
  logic       load_acc;
  logic       load_res;
  logic       signed_mult;
  acc_t       acc_q;
  acc_t       accum;
  acc_t       sum;
  word_t      low_word;
  word_t      result_q;

  // first phase sum shifted down by a half word for the ah*bh step
  assign signed_mult = (req_i.signed_mode != 2'b00);
  assign accum = {{half_w{signed_mult & acc_q[acc_w-1]}}, acc_q[acc_w-1:half_w]};

  vec_mult_lanes u_lanes (
    .req_i        (req_i),
    .high_phase_i (phase_q == PH_HIGH),
    .accum_i      (accum),
    .sum_o        (sum),
    .low_word_o   (low_word)
  );

  always_comb begin
    phase_d  = phase_q;
    done_d   = 1'b0;
    load_acc = 1'b0;
    load_res = 1'b0;
    case (phase_q)
      PH_LOW: begin
        if (start_i) begin
          if (req_i.op == MD_OP_MULH) begin
            phase_d  = PH_HIGH;
            load_acc = 1'b1;
          end else begin
            done_d   = 1'b1;
            load_res = 1'b1;
          end
        end
      end
      PH_HIGH: begin
        phase_d  = PH_LOW;
        done_d   = 1'b1;
        load_res = 1'b1;
      end
      default: begin
        phase_d = PH_LOW;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PH_LOW;
      done_q  <= 1'b0;
    end else begin
      phase_q <= phase_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_acc) begin
      acc_q <= sum;
    end
    if (load_res) begin
      result_q <= (phase_q == PH_HIGH) ? sum[word_w-1:0] : low_word;
    end
  end

  assign done_o   = done_q;
  assign result_o = result_q;

  // phase must be known once out of reset
  assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(phase_q));

endmodule

`default_nettype wire

/* tb_muldiv.sv */
/*
 * Testbench for the multiply/divide unit. Vectors come from muldiv_tests.txt,
 * read from the project root. Inputs change on the falling clock edge, and
 * outputs are sampled there too.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv;

  import muldiv_pkg::*;

  logic    clk_i;
  logic    rst_ni;
  logic    req_valid_i;
  md_req_t req_i;
  logic    ready_o;
  logic    valid_o;
  word_t   result_o;

  md_req_t test_req [$];
  word_t   test_exp [$];
  int      pulse_count;
  int      cycle_count;
  int      cycle_limit;

  muldiv_unit uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .ready_o     (ready_o),
    .valid_o     (valid_o),
    .result_o    (result_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  ////////////////////
  // monitors
  ////////////////////

  // every valid_o pulse is seen at exactly one falling edge
  always @(negedge clk_i) begin
    if (rst_ni && valid_o) begin
      pulse_count++;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // checks
  ////////////////////

  task automatic check_result(input word_t actual, input word_t expected, input int idx);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: test %0d gave %h, expected %h", $time, idx, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_idle(input logic ready, input logic valid);
    if (ready !== 1'b1 || valid !== 1'b0) begin
      $display("ERROR at %0t ns: ready_o=%b valid_o=%b, expected 1 and 0",
               $time, ready, valid);
      $display("*** TEST FAILED ***");
      $fatal(1, "handshake not idle");
    end
  endtask

  task automatic check_count(input int actual, input int expected);
    if (actual != expected) begin
      $display("ERROR at %0t ns: saw %0d valid_o pulses, expected %0d",
               $time, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "pulse count mismatch");
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic load_tests();
    int         fd;
    int         code;
    string      line;
    logic [1:0] op_v;
    logic [1:0] sm_v;
    logic       vec_v;
    logic [1:0] vsew_v;
    word_t      a_v;
    word_t      b_v;
    word_t      e_v;
    md_req_t    r;
    fd = $fopen("muldiv_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open muldiv_tests.txt");
      $display("*** TEST FAILED ***");
      $fatal(1, "missing vector file");
    end
    while ($fgets(line, fd) != 0) begin
      // skip comment and blank lines
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      code = $sscanf(line, "%h %h %h %h %h %h %h", op_v, sm_v, vec_v, vsew_v, a_v, b_v, e_v);
      if (code != 7) begin
        $display("malformed line in muldiv_tests.txt: %s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "bad vector file");
      end
      r.op          = md_op_e'(op_v);
      r.signed_mode = sm_v;
      r.vec         = vec_v;
      r.vsew        = vsew_e'(vsew_v);
      r.op_a        = a_v;
      r.op_b        = b_v;
      test_req.push_back(r);
      test_exp.push_back(e_v);
    end
    $fclose(fd);
  endtask

  task automatic issue_request(input md_req_t r);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    req_i       = r;
    req_valid_i = 1'b1;
    // accepted on this rising edge
    @(negedge clk_i);
    // valid stays high while busy, this must not start a second operation
    @(negedge clk_i);
    req_valid_i = 1'b0;
    req_i       = '0;
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    pulse_count = 0;
    cycle_count = 0;
    cycle_limit = 0;

    load_tests();
    cycle_limit = test_req.size() * 45 + 100;

    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_idle(ready_o, valid_o);
    check_result(result_o, '0, -1);

    for (int i = 0; i < test_req.size(); i++) begin
      issue_request(test_req[i]);
      while (!valid_o) begin
        @(negedge clk_i);
      end
      check_result(result_o, test_exp[i], i);
      @(negedge clk_i);
    end

    // extra cycles to catch a stray pulse
    repeat (10) @(negedge clk_i);
    check_count(pulse_count, test_req.size());
    check_idle(ready_o, valid_o);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* vec_mult_lanes.sv */
/*
 * Combinational datapath of the fracturable multiplier. The high phase
 * expects the accumulator already shifted and sign extended by the caller.
 * Vector packing is only applied for MUL with element width 8 or 16.
 */
`timescale 1ns/1ps
`default_nettype none

module vec_mult_lanes (
  input  muldiv_pkg::md_req_t req_i,
  input  logic                high_phase_i,
  input  muldiv_pkg::acc_t    accum_i,
  output muldiv_pkg::acc_t    sum_o,
  output muldiv_pkg::word_t   low_word_o
);

  import muldiv_pkg::*;

  logic                    vec_mode;
  logic                    sign_a;
  logic                    sign_b;
  logic [half_w:0]         mul_a [3];
  logic [half_w:0]         mul_b [3];
  logic signed [acc_w-1:0] mul_p [3];
  logic [7:0]              byte3_p;
  acc_t                    summand [3];

  // the vector flag only matters for the low word of MUL
  assign vec_mode = req_i.vec && (req_i.op == MD_OP_MULL) &&
                    (req_i.vsew == VSEW_8 || req_i.vsew == VSEW_16);

  assign sign_a = req_i.signed_mode[0] & req_i.op_a[word_w-1];
  assign sign_b = req_i.signed_mode[1] & req_i.op_b[word_w-1];

  ////////////////////
  // operand steering
  ////////////////////

  always_comb begin
    // scalar low phase: al*bl, al*bh, ah*bl
    mul_a[0] = {1'b0, req_i.op_a[half_w-1:0]};
    mul_b[0] = {1'b0, req_i.op_b[half_w-1:0]};
    mul_a[1] = {1'b0, req_i.op_a[half_w-1:0]};
    mul_b[1] = {sign_b, req_i.op_b[word_w-1:half_w]};
    mul_a[2] = {sign_a, req_i.op_a[word_w-1:half_w]};
    mul_b[2] = {1'b0, req_i.op_b[half_w-1:0]};

    // high phase reuses the third multiplier for ah*bh
    if (high_phase_i) begin
      mul_b[2] = {sign_b, req_i.op_b[word_w-1:half_w]};
    end

    if (vec_mode) begin
      case (req_i.vsew)
        VSEW_8: begin
          // bytes 0..2, byte 3 goes to the 8-bit multiplier
          for (int i = 0; i < 3; i++) begin
            mul_a[i] = {{(half_w-7){req_i.op_a[8*i+7]}}, req_i.op_a[8*i +: 8]};
            mul_b[i] = {{(half_w-7){req_i.op_b[8*i+7]}}, req_i.op_b[8*i +: 8]};
          end
        end
        VSEW_16: begin
          mul_a[0] = {req_i.op_a[half_w-1], req_i.op_a[half_w-1:0]};
          mul_b[0] = {req_i.op_b[half_w-1], req_i.op_b[half_w-1:0]};
          mul_a[1] = {req_i.op_a[word_w-1], req_i.op_a[word_w-1:half_w]};
          mul_b[1] = {req_i.op_b[word_w-1], req_i.op_b[word_w-1:half_w]};
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////
  // multipliers
  ////////////////////

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      mul_p[i] = $signed(mul_a[i]) * $signed(mul_b[i]);
    end
  end

  // only the low byte is kept, so signedness does not matter here
  assign byte3_p = req_i.op_a[word_w-1:24] * req_i.op_b[word_w-1:24];

  ////////////////////
  // summation
  ////////////////////

  always_comb begin
    if (high_phase_i) begin
      summand[0] = accum_i;
      summand[1] = '0;
      summand[2] = mul_p[2];
    end else begin
      // al*bl is unsigned, only its upper half lines up with the cross terms
      summand[0] = {{(acc_w-half_w){1'b0}}, mul_p[0][2*half_w-1:half_w]};
      summand[1] = mul_p[1];
      summand[2] = mul_p[2];
    end
  end

  assign sum_o = summand[0] + summand[1] + summand[2];

  always_comb begin
    low_word_o = {sum_o[half_w-1:0], mul_p[0][half_w-1:0]};
    if (vec_mode) begin
      if (req_i.vsew == VSEW_8) begin
        low_word_o = {byte3_p, mul_p[2][7:0], mul_p[1][7:0], mul_p[0][7:0]};
      end else begin
        // each halfword product stays in its own half
        low_word_o = {mul_p[1][half_w-1:0], mul_p[0][half_w-1:0]};
      end
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
muldiv_pkg.sv
vec_mult_lanes.sv
mult_seq.sv
long_divider.sv
muldiv_unit.sv
tb_muldiv.sv
